// File: source/periph_link_pkg.sv
`default_nettype none

package periph_link_pkg;

  ////////////////////
  // Link widths
  ////////////////////

  localparam int unsigned LINK_ADDRW = 32;
  localparam int unsigned LINK_DATAW = 32;
  localparam int unsigned LINK_STRBW = LINK_DATAW / 8;

  ////////////////////
  // Address map
  ////////////////////

  // ROM window must be aligned to its own size
  localparam logic [LINK_ADDRW-1:0] BOOT_ROM_BASE = 32'h0000_1000;
  localparam int unsigned BOOT_ROM_WORDS = 16;

  localparam logic [LINK_ADDRW-1:0] UART_BASE = 32'h0000_2000;
  localparam logic [LINK_ADDRW-1:0] UART_TXDATA_OFS = 32'h0000_0000;
  localparam logic [LINK_ADDRW-1:0] UART_STATUS_OFS = 32'h0000_0004;

  localparam logic [1:0] AXIL_RESP_OKAY = 2'b00;
  localparam logic [1:0] AXIL_RESP_SLVERR = 2'b10;

  // Boot image, prints two characters through the UART and parks
  localparam logic [LINK_DATAW-1:0] BOOT_ROM_INIT [BOOT_ROM_WORDS] = '{
    32'h0000_0093, 32'h0000_0113, 32'h0000_0193, 32'h0000_0213,
    32'h0000_22b7, 32'h0480_0313, 32'h0062_a023, 32'h0042_a383,
    32'h0013_f393, 32'hfe03_9ce3, 32'h0690_0313, 32'h0062_a023,
    32'h1050_0073, 32'hffdf_f06f, 32'h0000_0013, 32'h0000_0013
  };

  ////////////////////
  // Bus structs
  ////////////////////

  typedef struct packed {
    logic                  valid;
    logic                  write;
    logic [LINK_ADDRW-1:0] addr;
    logic [LINK_DATAW-1:0] wdata;
    logic [LINK_STRBW-1:0] strb;
  } link_req_t;

  typedef struct packed {
    logic                  done;
    logic [LINK_DATAW-1:0] rdata;
    logic                  err;
  } link_resp_t;

  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [LINK_ADDRW-1:0] paddr;
    logic [LINK_DATAW-1:0] pwdata;
    logic [LINK_STRBW-1:0] pstrb;
  } apb_req_t;

  typedef struct packed {
    logic                  pready;
    logic [LINK_DATAW-1:0] prdata;
    logic                  pslverr;
  } apb_resp_t;

  typedef struct packed {
    logic                  aw_valid;
    logic [LINK_ADDRW-1:0] aw_addr;
    logic                  w_valid;
    logic [LINK_DATAW-1:0] w_data;
    logic [LINK_STRBW-1:0] w_strb;
    logic                  b_ready;
    logic                  ar_valid;
    logic [LINK_ADDRW-1:0] ar_addr;
    logic                  r_ready;
  } axil_req_t;

  typedef struct packed {
    logic                  aw_ready;
    logic                  w_ready;
    logic                  b_valid;
    logic [1:0]            b_resp;
    logic                  ar_ready;
    logic                  r_valid;
    logic [LINK_DATAW-1:0] r_data;
    logic [1:0]            r_resp;
  } axil_resp_t;

endpackage

`default_nettype wire

// File: source/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
  parameter int unsigned CLKS_PER_BIT = 8
) (
  input  logic       periphl_clk_i,
  input  logic       rst_n_i,
  input  logic       load_i,
  input  logic [7:0] data_i,
  output logic       busy_o,
  output logic       tx_o
);

  localparam int unsigned CNT_W = $clog2(CLKS_PER_BIT + 1);

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_e;

  tx_state_e        state_q;
  logic [CNT_W-1:0] cnt_q;
  logic [2:0]       bit_idx_q;
  logic [7:0]       shift_q;
  logic             bit_end;

  // Last clock of the current bit period
  assign bit_end = (cnt_q == CNT_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge periphl_clk_i) begin
    if (!rst_n_i) begin
      state_q   <= TX_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
    end else begin
      cnt_q <= bit_end ? '0 : cnt_q + 1'b1;
      case (state_q)
        TX_IDLE: begin
          cnt_q     <= '0;
          bit_idx_q <= '0;
          if (load_i) state_q <= TX_START;
        end
        TX_START: if (bit_end) state_q <= TX_DATA;
        TX_DATA: begin
          if (bit_end) begin
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) state_q <= TX_STOP;
          end
        end
        TX_STOP: if (bit_end) state_q <= TX_IDLE;
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  // LSB goes out first
  always_ff @(posedge periphl_clk_i) begin
    if (state_q == TX_IDLE && load_i) shift_q <= data_i;
    else if (state_q == TX_DATA && bit_end) shift_q <= {1'b0, shift_q[7:1]};
  end

  always_comb begin
    case (state_q)
      TX_START: tx_o = 1'b0;
      TX_DATA:  tx_o = shift_q[0];
      default:  tx_o = 1'b1;
    endcase
  end

  assign busy_o = (state_q != TX_IDLE);

endmodule

`default_nettype wire

// File: source/apb_slave_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module apb_slave_bridge (
  input  logic                         periphl_clk_i,
  input  logic                         rst_n_i,
  input  periph_link_pkg::apb_req_t    apb_req_i,
  output periph_link_pkg::apb_resp_t   apb_resp_o,
  output periph_link_pkg::link_req_t   link_req_o,
  input  periph_link_pkg::link_resp_t  link_resp_i
);

  import periph_link_pkg::*;

  typedef enum logic [1:0] {
    APB_IDLE,
    APB_WAIT,
    APB_RESPOND
  } apb_state_e;

  apb_state_e            state_q;
  logic                  access;
  logic                  write_q;
  logic [LINK_ADDRW-1:0] addr_q;
  logic [LINK_DATAW-1:0] wdata_q;
  logic [LINK_STRBW-1:0] strb_q;
  logic [LINK_DATAW-1:0] rdata_q;
  logic                  err_q;

  assign access = apb_req_i.psel & apb_req_i.penable;

  always_ff @(posedge periphl_clk_i) begin
    if (!rst_n_i) begin
      state_q <= APB_IDLE;
    end else begin
      case (state_q)
        APB_IDLE:    if (access) state_q <= APB_WAIT;
        APB_WAIT:    if (link_resp_i.done) state_q <= APB_RESPOND;
        APB_RESPOND: state_q <= APB_IDLE;
        default:     state_q <= APB_IDLE;
      endcase
    end
  end

  // Transfer is stable from setup onwards, so capture it while idle
  always_ff @(posedge periphl_clk_i) begin
    if (state_q == APB_IDLE && apb_req_i.psel) begin
      write_q <= apb_req_i.pwrite;
      addr_q  <= apb_req_i.paddr;
      wdata_q <= apb_req_i.pwdata;
      strb_q  <= apb_req_i.pstrb;
    end
    if (state_q == APB_WAIT && link_resp_i.done) begin
      rdata_q <= link_resp_i.rdata;
      err_q   <= link_resp_i.err;
    end
  end

  // Request from the first access cycle, dropped once the answer is back
  assign link_req_o.valid = access & (state_q != APB_RESPOND);
  assign link_req_o.write = write_q;
  assign link_req_o.addr  = addr_q;
  assign link_req_o.wdata = wdata_q;
  assign link_req_o.strb  = strb_q;

  assign apb_resp_o.pready  = (state_q == APB_RESPOND);
  assign apb_resp_o.prdata  = rdata_q;
  assign apb_resp_o.pslverr = err_q & (state_q == APB_RESPOND);

endmodule

`default_nettype wire

// File: source/sysl_lite_port.sv
`timescale 1ns/1ps
`default_nettype none

module sysl_lite_port (
  input  logic                         periphl_clk_i,
  input  logic                         rst_n_i,
  input  periph_link_pkg::axil_req_t   axil_req_i,
  output periph_link_pkg::axil_resp_t  axil_resp_o,
  output periph_link_pkg::link_req_t   link_req_o,
  input  periph_link_pkg::link_resp_t  link_resp_i
);

  import periph_link_pkg::*;

  typedef enum logic [2:0] {
    SP_COLLECT,
    SP_WR_ACCESS,
    SP_RD_ACCESS,
    SP_WR_RESP,
    SP_RD_RESP
  } sp_state_e;

  sp_state_e             state_q;
  logic                  aw_have_q;
  logic                  w_have_q;
  logic                  ar_have_q;
  logic [LINK_ADDRW-1:0] aw_addr_q;
  logic [LINK_ADDRW-1:0] ar_addr_q;
  logic [LINK_DATAW-1:0] w_data_q;
  logic [LINK_STRBW-1:0] w_strb_q;
  logic [LINK_DATAW-1:0] rdata_q;
  logic [1:0]            resp_q;
  logic                  aw_ready;
  logic                  w_ready;
  logic                  ar_ready;

  // Beats are only taken while no transaction or response is pending
  assign aw_ready = (state_q == SP_COLLECT) & ~aw_have_q;
  assign w_ready  = (state_q == SP_COLLECT) & ~w_have_q;
  assign ar_ready = (state_q == SP_COLLECT) & ~ar_have_q;

  always_ff @(posedge periphl_clk_i) begin
    if (!rst_n_i) begin
      state_q   <= SP_COLLECT;
      aw_have_q <= 1'b0;
      w_have_q  <= 1'b0;
      ar_have_q <= 1'b0;
    end else begin
      if (axil_req_i.aw_valid && aw_ready) aw_have_q <= 1'b1;
      if (axil_req_i.w_valid && w_ready) w_have_q <= 1'b1;
      if (axil_req_i.ar_valid && ar_ready) ar_have_q <= 1'b1;
      case (state_q)
        // Complete write first
        SP_COLLECT: begin
          if (aw_have_q && w_have_q) state_q <= SP_WR_ACCESS;
          else if (ar_have_q) state_q <= SP_RD_ACCESS;
        end
        SP_WR_ACCESS: begin
          if (link_resp_i.done) begin
            state_q   <= SP_WR_RESP;
            aw_have_q <= 1'b0;
            w_have_q  <= 1'b0;
          end
        end
        SP_RD_ACCESS: begin
          if (link_resp_i.done) begin
            state_q   <= SP_RD_RESP;
            ar_have_q <= 1'b0;
          end
        end
        SP_WR_RESP: if (axil_req_i.b_ready) state_q <= SP_COLLECT;
        SP_RD_RESP: if (axil_req_i.r_ready) state_q <= SP_COLLECT;
        default:    state_q <= SP_COLLECT;
      endcase
    end
  end

  always_ff @(posedge periphl_clk_i) begin
    if (axil_req_i.aw_valid && aw_ready) aw_addr_q <= axil_req_i.aw_addr;
    if (axil_req_i.ar_valid && ar_ready) ar_addr_q <= axil_req_i.ar_addr;
    if (axil_req_i.w_valid && w_ready) begin
      w_data_q <= axil_req_i.w_data;
      w_strb_q <= axil_req_i.w_strb;
    end
    if (link_resp_i.done) begin
      rdata_q <= link_resp_i.rdata;
      resp_q  <= link_resp_i.err ? AXIL_RESP_SLVERR : AXIL_RESP_OKAY;
    end
  end

  assign link_req_o.valid = (state_q == SP_WR_ACCESS) | (state_q == SP_RD_ACCESS);
  assign link_req_o.write = (state_q == SP_WR_ACCESS);
  assign link_req_o.addr  = (state_q == SP_WR_ACCESS) ? aw_addr_q : ar_addr_q;
  assign link_req_o.wdata = w_data_q;
  assign link_req_o.strb  = (state_q == SP_WR_ACCESS) ? w_strb_q : '0;

  assign axil_resp_o.aw_ready = aw_ready;
  assign axil_resp_o.w_ready  = w_ready;
  assign axil_resp_o.b_valid  = (state_q == SP_WR_RESP);
  assign axil_resp_o.b_resp   = resp_q;
  assign axil_resp_o.ar_ready = ar_ready;
  assign axil_resp_o.r_valid  = (state_q == SP_RD_RESP);
  assign axil_resp_o.r_data   = rdata_q;
  assign axil_resp_o.r_resp   = resp_q;

endmodule

`default_nettype wire

// File: source/peripheral_link.sv
`timescale 1ns/1ps
`default_nettype none

module peripheral_link #(
  parameter int unsigned CLKS_PER_BIT = 8
) (
  input  logic                         periphl_clk_i,
  input  logic                         rst_n_i,
  input  periph_link_pkg::link_req_t   apb_link_req_i,
  input  periph_link_pkg::link_req_t   sysl_link_req_i,
  output periph_link_pkg::link_resp_t  apb_link_resp_o,
  output periph_link_pkg::link_resp_t  sysl_link_resp_o,
  output logic                         uart_tx_o
);

  import periph_link_pkg::*;

  // Byte address bits covered by the ROM window
  localparam int unsigned ROM_AW = $clog2(BOOT_ROM_WORDS) + 2;

  typedef enum logic [1:0] {
    LINK_IDLE,
    LINK_ACCESS,
    LINK_UART_WAIT
  } link_state_e;

  link_state_e           state_q;
  logic                  grant_q;
  logic                  grant_d;
  logic                  done_q;
  logic [LINK_DATAW-1:0] rdata_q;
  logic                  err_q;
  logic                  apb_elig;
  logic                  sysl_elig;
  logic                  active;
  link_req_t             req;
  logic                  rom_hit;
  logic                  txdata_hit;
  logic                  status_hit;
  logic [LINK_DATAW-1:0] rdata_d;
  logic                  err_d;
  logic                  finish;
  logic                  uart_load;
  logic                  uart_busy;

  ////////////////////
  // Round-robin grant
  ////////////////////

  // A requester seeing done still holds valid for that cycle, so mask it
  assign apb_elig  = apb_link_req_i.valid & ~(done_q & ~grant_q);
  assign sysl_elig = sysl_link_req_i.valid & ~(done_q & grant_q);

  // grant_q keeps the last served requester, the other one wins a tie
  assign grant_d = (apb_elig && sysl_elig) ? ~grant_q : sysl_elig;

  always_ff @(posedge periphl_clk_i) begin
    if (!rst_n_i) begin
      state_q <= LINK_IDLE;
      grant_q <= 1'b1;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        LINK_IDLE: begin
          if (apb_elig || sysl_elig) begin
            state_q <= LINK_ACCESS;
            grant_q <= grant_d;
          end
        end
        LINK_ACCESS, LINK_UART_WAIT: begin
          if (finish) begin
            state_q <= LINK_IDLE;
            done_q  <= 1'b1;
          end else begin
            state_q <= LINK_UART_WAIT;
          end
        end
        default: state_q <= LINK_IDLE;
      endcase
    end
  end

  ////////////////////
  // Address decode
  ////////////////////

  assign active = (state_q == LINK_ACCESS) | (state_q == LINK_UART_WAIT);
  assign req    = grant_q ? sysl_link_req_i : apb_link_req_i;

  assign rom_hit    = req.addr[LINK_ADDRW-1:ROM_AW] == BOOT_ROM_BASE[LINK_ADDRW-1:ROM_AW];
  assign txdata_hit = req.addr == (UART_BASE + UART_TXDATA_OFS);
  assign status_hit = req.addr == (UART_BASE + UART_STATUS_OFS);

  always_comb begin
    rdata_d   = '0;
    err_d     = 1'b0;
    finish    = 1'b1;
    uart_load = 1'b0;
    if (rom_hit) begin
      if (req.write) err_d = 1'b1;
      else rdata_d = BOOT_ROM_INIT[req.addr[ROM_AW-1:2]];
    end else if (txdata_hit) begin
      // Hold the access until the transmitter is free
      if (req.write && req.strb[0]) begin
        finish    = ~uart_busy;
        uart_load = active & ~uart_busy;
      end
    end else if (status_hit) begin
      rdata_d = {{(LINK_DATAW-1){1'b0}}, uart_busy};
    end else begin
      // Default slave
      err_d = 1'b1;
    end
  end

  always_ff @(posedge periphl_clk_i) begin
    if (active && finish) begin
      rdata_q <= rdata_d;
      err_q   <= err_d;
    end
  end

  assign apb_link_resp_o.done   = done_q & ~grant_q;
  assign apb_link_resp_o.rdata  = rdata_q;
  assign apb_link_resp_o.err    = err_q;
  assign sysl_link_resp_o.done  = done_q & grant_q;
  assign sysl_link_resp_o.rdata = rdata_q;
  assign sysl_link_resp_o.err   = err_q;

  ////////////////////
  // UART
  ////////////////////

  uart_tx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) uart_device (
    .periphl_clk_i(periphl_clk_i),
    .rst_n_i      (rst_n_i),
    .load_i       (uart_load),
    .data_i       (req.wdata[7:0]),
    .busy_o       (uart_busy),
    .tx_o         (uart_tx_o)
  );

endmodule

`default_nettype wire

// File: source/periph_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

module periph_subsystem_top #(
  parameter int unsigned CLKS_PER_BIT = 8
) (
  input  logic                         periphl_clk_i,
  input  logic                         rst_n_i,
  input  periph_link_pkg::apb_req_t    apb_req_i,
  output periph_link_pkg::apb_resp_t   apb_resp_o,
  input  periph_link_pkg::axil_req_t   sysl_axil_req_i,
  output periph_link_pkg::axil_resp_t  sysl_axil_resp_o,
  output logic                         uart_tx_o
);

  import periph_link_pkg::*;

  link_req_t  apb_link_req;
  link_resp_t apb_link_resp;
  link_req_t  sysl_link_req;
  link_resp_t sysl_link_resp;

  ////////////////////
  // Requesters
  ////////////////////

  apb_slave_bridge apb_slave (
    .periphl_clk_i(periphl_clk_i),
    .rst_n_i      (rst_n_i),
    .apb_req_i    (apb_req_i),
    .apb_resp_o   (apb_resp_o),
    .link_req_o   (apb_link_req),
    .link_resp_i  (apb_link_resp)
  );

  sysl_lite_port sysl_port (
    .periphl_clk_i(periphl_clk_i),
    .rst_n_i      (rst_n_i),
    .axil_req_i   (sysl_axil_req_i),
    .axil_resp_o  (sysl_axil_resp_o),
    .link_req_o   (sysl_link_req),
    .link_resp_i  (sysl_link_resp)
  );

  // ROM, UART and default slave all live behind the link
  peripheral_link #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) periph_link (
    .periphl_clk_i   (periphl_clk_i),
    .rst_n_i         (rst_n_i),
    .apb_link_req_i  (apb_link_req),
    .sysl_link_req_i (sysl_link_req),
    .apb_link_resp_o (apb_link_resp),
    .sysl_link_resp_o(sysl_link_resp),
    .uart_tx_o       (uart_tx_o)
  );

endmodule

`default_nettype wire

// File: tb/periph_subsystem_properties.sv
`timescale 1ns/1ps
`default_nettype none

module periph_subsystem_properties (
  input logic                        periphl_clk_i,
  input logic                        rst_n_i,
  input periph_link_pkg::link_req_t  apb_link_req_i,
  input periph_link_pkg::link_req_t  sysl_link_req_i,
  input periph_link_pkg::link_resp_t apb_link_resp_i,
  input periph_link_pkg::link_resp_t sysl_link_resp_i,
  input logic                        uart_busy_i,
  input logic                        uart_tx_i
);

  // Only one requester answered per cycle
  done_exclusive: assert property (@(posedge periphl_clk_i) disable iff (!rst_n_i)
    !(apb_link_resp_i.done && sysl_link_resp_i.done))
    else $error("done pulsed to both requesters in the same cycle");

  apb_valid_held: assert property (@(posedge periphl_clk_i) disable iff (!rst_n_i)
    apb_link_req_i.valid && !apb_link_resp_i.done |=> apb_link_req_i.valid)
    else $error("APB bridge dropped valid before its done");

  sysl_valid_held: assert property (@(posedge periphl_clk_i) disable iff (!rst_n_i)
    sysl_link_req_i.valid && !sysl_link_resp_i.done |=> sysl_link_req_i.valid)
    else $error("AXI-lite port dropped valid before its done");

  // Line idles high between frames
  uart_idle_high: assert property (@(posedge periphl_clk_i) disable iff (!rst_n_i)
    !uart_busy_i |-> uart_tx_i)
    else $error("uart_tx_o low while the transmitter is idle");

endmodule

bind peripheral_link periph_subsystem_properties link_props (
  .periphl_clk_i   (periphl_clk_i),
  .rst_n_i         (rst_n_i),
  .apb_link_req_i  (apb_link_req_i),
  .sysl_link_req_i (sysl_link_req_i),
  .apb_link_resp_i (apb_link_resp_o),
  .sysl_link_resp_i(sysl_link_resp_o),
  .uart_busy_i     (uart_busy),
  .uart_tx_i       (uart_tx_o)
);

`default_nettype wire

// File: tb/periph_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module periph_subsystem_tb;

  import periph_link_pkg::*;

  localparam int unsigned CLKS_PER_BIT = 4;
  localparam int unsigned SEED = 32'he9cc_fc49;
  localparam logic [LINK_ADDRW-1:0] TXDATA_ADDR = UART_BASE + UART_TXDATA_OFS;

  // One line of the vectors file
  typedef struct packed {
    logic [3:0]  port;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        err;
  } vector_t;

  logic        periphl_clk = 1'b0;
  logic        rst_n;
  apb_req_t    apb_req;
  apb_resp_t   apb_resp;
  axil_req_t   axil_req;
  axil_resp_t  axil_resp;
  logic        uart_tx;
  vector_t     vectors[$];
  logic [7:0]  uart_expected[$];
  int unsigned cycle_count = 0;
  int unsigned cycle_limit = 0;

  periph_subsystem_top #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) dut0 (
    .periphl_clk_i   (periphl_clk),
    .rst_n_i         (rst_n),
    .apb_req_i       (apb_req),
    .apb_resp_o      (apb_resp),
    .sysl_axil_req_i (axil_req),
    .sysl_axil_resp_o(axil_resp),
    .uart_tx_o       (uart_tx)
  );

  always #10 periphl_clk = ~periphl_clk;

  ////////////////////
  // Checks
  ////////////////////

  task automatic stop_with_failure();
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("error at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
      stop_with_failure();
    end
  endtask

  // A held response blocks every new beat
  task automatic check_backpressure();
    check_value("aw_ready", 32'd0, {31'd0, axil_resp.aw_ready});
    check_value("w_ready", 32'd0, {31'd0, axil_resp.w_ready});
    check_value("ar_ready", 32'd0, {31'd0, axil_resp.ar_ready});
  endtask

  always @(posedge periphl_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("timeout after %0d cycles, the DUT hangs", cycle_count);
      stop_with_failure();
    end
  end

  ////////////////////
  // Bus drivers
  ////////////////////

  task automatic apb_access(input vector_t vec, output logic [31:0] rdata,
                            output logic err);
    @(negedge periphl_clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = vec.write;
    apb_req.paddr   = vec.addr;
    apb_req.pwdata  = vec.wdata;
    apb_req.pstrb   = '1;
    @(negedge periphl_clk);
    apb_req.penable = 1'b1;
    // Wait states last until the link answers
    @(negedge periphl_clk);
    while (!apb_resp.pready) @(negedge periphl_clk);
    rdata = apb_resp.prdata;
    err   = apb_resp.pslverr;
    @(negedge periphl_clk);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic axil_write(input vector_t vec, output logic [1:0] resp);
    logic aw_hs;
    logic w_hs;
    @(negedge periphl_clk);
    axil_req.aw_valid = 1'b1;
    axil_req.aw_addr  = vec.addr;
    axil_req.w_valid  = 1'b1;
    axil_req.w_data   = vec.wdata;
    axil_req.w_strb   = '1;
    // Address and data beats may be taken in different cycles
    while (axil_req.aw_valid || axil_req.w_valid) begin
      aw_hs = axil_req.aw_valid & axil_resp.aw_ready;
      w_hs  = axil_req.w_valid & axil_resp.w_ready;
      @(negedge periphl_clk);
      if (aw_hs) axil_req.aw_valid = 1'b0;
      if (w_hs) axil_req.w_valid = 1'b0;
    end
    while (!axil_resp.b_valid) @(negedge periphl_clk);
    check_backpressure();
    repeat ($urandom_range(3, 0)) @(negedge periphl_clk);
    check_value("b_valid", 32'd1, {31'd0, axil_resp.b_valid});
    check_backpressure();
    resp = axil_resp.b_resp;
    axil_req.b_ready = 1'b1;
    @(negedge periphl_clk);
    axil_req.b_ready = 1'b0;
  endtask

  task automatic axil_read(input vector_t vec, output logic [31:0] rdata,
                           output logic [1:0] resp);
    @(negedge periphl_clk);
    axil_req.ar_valid = 1'b1;
    axil_req.ar_addr  = vec.addr;
    while (!axil_resp.ar_ready) @(negedge periphl_clk);
    @(negedge periphl_clk);
    axil_req.ar_valid = 1'b0;
    while (!axil_resp.r_valid) @(negedge periphl_clk);
    check_backpressure();
    repeat ($urandom_range(3, 0)) @(negedge periphl_clk);
    check_value("r_valid", 32'd1, {31'd0, axil_resp.r_valid});
    check_backpressure();
    rdata = axil_resp.r_data;
    resp  = axil_resp.r_resp;
    axil_req.r_ready = 1'b1;
    @(negedge periphl_clk);
    axil_req.r_ready = 1'b0;
  endtask

  task automatic run_vector(input vector_t vec, input bit with_gap);
    logic [31:0] rdata;
    logic        err;
    logic [1:0]  resp;
    logic [1:0]  exp_resp;
    exp_resp = vec.err ? AXIL_RESP_SLVERR : AXIL_RESP_OKAY;
    if (with_gap) repeat ($urandom_range(3, 0)) @(negedge periphl_clk);
    // Byte has to show up on the line later
    if (vec.write && vec.addr == TXDATA_ADDR && !vec.err) begin
      uart_expected.push_back(vec.wdata[7:0]);
    end
    if (vec.port[0] == 1'b0) begin
      apb_access(vec, rdata, err);
      check_value("pslverr", {31'd0, vec.err}, {31'd0, err});
      if (!vec.write) check_value("prdata", vec.rdata, rdata);
    end else if (vec.write) begin
      axil_write(vec, resp);
      check_value("b_resp", {30'd0, exp_resp}, {30'd0, resp});
    end else begin
      axil_read(vec, rdata, resp);
      check_value("r_resp", {30'd0, exp_resp}, {30'd0, resp});
      check_value("r_data", vec.rdata, rdata);
    end
  endtask

  ////////////////////
  // UART line monitor
  ////////////////////

  initial begin : uart_monitor
    logic [7:0] rx_byte;
    logic       found;
    int         hit;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge uart_tx);
      // Sample near the middle of each bit
      repeat (CLKS_PER_BIT / 2) @(negedge periphl_clk);
      check_value("uart_tx_o start bit", 32'd0, {31'd0, uart_tx});
      for (int i = 0; i < 8; i++) begin
        repeat (CLKS_PER_BIT) @(negedge periphl_clk);
        rx_byte[i] = uart_tx;
      end
      repeat (CLKS_PER_BIT) @(negedge periphl_clk);
      check_value("uart_tx_o stop bit", 32'd1, {31'd0, uart_tx});
      found = 1'b0;
      hit   = 0;
      foreach (uart_expected[k]) begin
        if (!found && uart_expected[k] == rx_byte) begin
          found = 1'b1;
          hit   = k;
        end
      end
      assert (found) else begin
        $display("error at %0t ns: uart_tx_o sent byte %h that no TXDATA write asked for",
                 $time, rx_byte);
        stop_with_failure();
      end
      uart_expected.delete(hit);
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin : main_sequence
    int          fd;
    int          count;
    int          idx;
    string       token;
    string       rest;
    logic [31:0] port_f;
    logic [31:0] write_f;
    logic [31:0] addr_f;
    logic [31:0] wdata_f;
    logic [31:0] rdata_f;
    logic [31:0] err_f;
    vector_t     vec;
    apb_req  = '0;
    axil_req = '0;
    rst_n    = 1'b0;
    void'($urandom(SEED));
    fd = $fopen("tb/periph_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open tb/periph_vectors.txt");
      stop_with_failure();
    end
    while ($fscanf(fd, "%s", token) == 1) begin
      if (token.substr(0, 0) == "#") begin
        void'($fgets(rest, fd));
      end else begin
        count = $sscanf(token, "%h", port_f);
        count += $fscanf(fd, "%h %h %h %h %h", write_f, addr_f, wdata_f, rdata_f, err_f);
        if (count != 6) begin
          $display("vector %0d in tb/periph_vectors.txt is malformed", vectors.size() + 1);
          stop_with_failure();
        end
        vec.port  = port_f[3:0];
        vec.write = write_f[0];
        vec.addr  = addr_f;
        vec.wdata = wdata_f;
        vec.rdata = rdata_f;
        vec.err   = err_f[0];
        vectors.push_back(vec);
      end
    end
    $fclose(fd);
    cycle_limit = vectors.size() * (12 * CLKS_PER_BIT + 40);

    repeat (16) @(negedge periphl_clk);
    rst_n = 1'b1;
    check_value("uart_tx_o", 32'd1, {31'd0, uart_tx});
    check_value("pready", 32'd0, {31'd0, apb_resp.pready});
    check_value("b_valid", 32'd0, {31'd0, axil_resp.b_valid});
    check_value("r_valid", 32'd0, {31'd0, axil_resp.r_valid});

    idx = 0;
    while (idx < vectors.size()) begin
      if (vectors[idx].port[1] && idx + 1 < vectors.size()) begin
        // Both ports start together and the link arbitrates
        fork
          run_vector(vectors[idx], 1'b0);
          run_vector(vectors[idx + 1], 1'b0);
        join
        idx += 2;
      end else begin
        run_vector(vectors[idx], 1'b1);
        idx += 1;
      end
    end

    // Frames still on the line
    while (uart_expected.size() != 0) @(negedge periphl_clk);
    // No byte goes out a second time
    repeat (12 * CLKS_PER_BIT) begin
      @(negedge periphl_clk);
      check_value("uart_tx_o", 32'd1, {31'd0, uart_tx});
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/periph_vectors.txt
# port op addr wdata exp_rdata exp_err, all hex; op 0 read, 1 write
# port 0 APB, 1 AXI-lite; 2 APB together with the next line on AXI-lite
0 0 00001000 00000000 00000093 0
0 0 00001014 00000000 04800313 0
0 0 0000103c 00000000 00000013 0
1 0 00001024 00000000 fe039ce3 0
1 0 00001030 00000000 10500073 0
1 1 00001024 deadbeef 00000000 1
1 0 00001024 00000000 fe039ce3 0
0 1 00001008 12345678 00000000 1
0 0 00001008 00000000 00000193 0
0 0 00003000 00000000 00000000 1
1 0 00000ffc 00000000 00000000 1
1 1 00002008 00000001 00000000 1
0 0 00002010 00000000 00000000 1
0 1 00002000 00000055 00000000 0
0 0 00002004 00000000 00000001 0
1 0 00002004 00000000 00000001 0
2 1 00002000 000000a3 00000000 0
1 1 00002000 0000003c 00000000 0
0 0 0000102c 00000000 0062a023 0
1 0 0000101c 00000000 0042a383 0
1 0 00001034 00000000 ffdff06f 0
0 0 00001010 00000000 000022b7 0

// File: list.f
source/periph_link_pkg.sv
source/uart_tx.sv
source/apb_slave_bridge.sv
source/sysl_lite_port.sv
source/peripheral_link.sv
source/periph_subsystem_top.sv
tb/periph_subsystem_properties.sv
tb/periph_subsystem_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := periph_subsystem_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Test failed
PASS_MSG  := Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
